//--- rtl/periph_pkg.sv
// Peripheral subsystem package
// Address map, register offsets, widths and shared types
package periph_pkg;

  localparam int ADDR_W   = 12;
  localparam int DATA_W   = 32;
  localparam int GPIO_W   = 8;
  localparam int NUM_SRC  = 4;
  localparam int SRC_ID_W = 2;
  localparam int SEL_W    = 2;
  localparam int OFF_W    = 8;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [GPIO_W-1:0]   gpio_t;
  typedef logic [NUM_SRC-1:0]  src_t;
  typedef logic [SRC_ID_W-1:0] src_id_t;
  typedef logic [SEL_W-1:0]    sel_t;
  typedef logic [OFF_W-1:0]    off_t;

  // Block select, address bits 11:8
  localparam sel_t SEL_GPIO  = 2'd0;
  localparam sel_t SEL_TIMER = 2'd1;
  localparam sel_t SEL_PLIC  = 2'd2;

  // GPIO registers
  localparam off_t GPIO_OUT = 8'h00;
  localparam off_t GPIO_EN  = 8'h04;
  localparam off_t GPIO_IN  = 8'h08;
  localparam off_t GPIO_IE  = 8'h0C;

  // Timer registers
  localparam off_t TMR_COUNT = 8'h00;
  localparam off_t TMR_CMP   = 8'h04;
  localparam off_t TMR_CTRL  = 8'h08;

  // PLIC registers
  localparam off_t PLIC_PEND  = 8'h00;
  localparam off_t PLIC_EN    = 8'h04;
  localparam off_t PLIC_CLAIM = 8'h08;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    HOLD
  } bridge_state_e;

endpackage : periph_pkg

//--- rtl/periph_bus_bridge.sv
`timescale 1ns/10ps
// Host bridge
// One register access per four-phase req/ack handshake with the response held until req drops
module periph_bus_bridge (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  output logic              ack_o,
  output periph_pkg::data_t rdata_o,
  output logic              err_o,
  output logic              reg_valid_o,
  output logic              reg_we_o,
  output periph_pkg::addr_t reg_addr_o,
  output periph_pkg::data_t reg_wdata_o,
  input  periph_pkg::data_t reg_rdata_i,
  input  logic              reg_err_i
);

  periph_pkg::bridge_state_e state_q;
  periph_pkg::data_t         rdata_q;
  logic                      err_q;
  logic                      we_q;
  periph_pkg::addr_t         addr_q;
  periph_pkg::data_t         wdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= periph_pkg::IDLE;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        periph_pkg::IDLE: begin
          if (req_i) state_q <= periph_pkg::ACCESS;
        end
        periph_pkg::ACCESS: begin
          // Capture the response at the end of the access cycle
          rdata_q <= reg_rdata_i;
          err_q   <= reg_err_i;
          state_q <= periph_pkg::HOLD;
        end
        periph_pkg::HOLD: begin
          if (!req_i) state_q <= periph_pkg::IDLE;
        end
        default: state_q <= periph_pkg::IDLE;
      endcase
    end
  end

  // Request fields sampled when the handshake starts
  always_ff @(posedge clk_i) begin
    if (state_q == periph_pkg::IDLE && req_i) begin
      we_q    <= we_i;
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
  end

  assign reg_valid_o = (state_q == periph_pkg::ACCESS);
  assign reg_we_o    = we_q;
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;
  assign ack_o       = (state_q == periph_pkg::HOLD);
  assign rdata_o     = rdata_q;
  assign err_o       = err_q;

  // The access happens while the host still holds req
  a_valid_with_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_valid_o |-> req_i);

  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(ack_o) |-> $past(req_i));

endmodule : periph_bus_bridge

//--- rtl/periph_addr_decode.sv
`timescale 1ns/10ps
// Register bus decoder
// Routes the access strobe by address bits 11:8 and returns read data or an error
module periph_addr_decode (
  input  logic              reg_valid_i,
  input  periph_pkg::addr_t reg_addr_i,
  output logic              gpio_valid_o,
  output logic              tmr_valid_o,
  output logic              plic_valid_o,
  input  periph_pkg::data_t gpio_rdata_i,
  input  periph_pkg::data_t tmr_rdata_i,
  input  periph_pkg::data_t plic_rdata_i,
  output periph_pkg::data_t reg_rdata_o,
  output logic              reg_err_o
);

  periph_pkg::sel_t sel;
  logic             in_range;
  logic             hit_gpio;
  logic             hit_tmr;
  logic             hit_plic;

  // Upper select bits must be zero for any mapped block
  assign sel      = reg_addr_i[9:8];
  assign in_range = (reg_addr_i[11:10] == 2'b00);

  assign hit_gpio = in_range && (sel == periph_pkg::SEL_GPIO);
  assign hit_tmr  = in_range && (sel == periph_pkg::SEL_TIMER);
  assign hit_plic = in_range && (sel == periph_pkg::SEL_PLIC);

  assign gpio_valid_o = reg_valid_i && hit_gpio;
  assign tmr_valid_o  = reg_valid_i && hit_tmr;
  assign plic_valid_o = reg_valid_i && hit_plic;

  always_comb begin
    reg_rdata_o = '0;
    if (hit_gpio) reg_rdata_o = gpio_rdata_i;
    else if (hit_tmr) reg_rdata_o = tmr_rdata_i;
    else if (hit_plic) reg_rdata_o = plic_rdata_i;
  end

  assign reg_err_o = !(hit_gpio || hit_tmr || hit_plic);

endmodule : periph_addr_decode

//--- rtl/periph_gpio.sv
`timescale 1ns/10ps
// GPIO block
// Output, output-enable and interrupt-enable registers plus synchronized inputs
module periph_gpio (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  output periph_pkg::data_t rdata_o,
  input  periph_pkg::gpio_t gpio_i,
  output periph_pkg::gpio_t gpio_o,
  output periph_pkg::gpio_t gpio_en_o,
  output logic              irq_o
);

  periph_pkg::gpio_t out_q;
  periph_pkg::gpio_t en_q;
  periph_pkg::gpio_t ie_q;
  periph_pkg::gpio_t sync1_q;
  periph_pkg::gpio_t sync2_q;
  periph_pkg::off_t  off;
  logic              wr;

  assign off = addr_i[7:0];
  assign wr  = valid_i && we_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q <= '0;
      en_q  <= '0;
      ie_q  <= '0;
    end else if (wr) begin
      case (off)
        periph_pkg::GPIO_OUT: out_q <= wdata_i[periph_pkg::GPIO_W-1:0];
        periph_pkg::GPIO_EN:  en_q  <= wdata_i[periph_pkg::GPIO_W-1:0];
        periph_pkg::GPIO_IE:  ie_q  <= wdata_i[periph_pkg::GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  // Two-flop pin synchronizer
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
    end
  end

  always_comb begin
    case (off)
      periph_pkg::GPIO_OUT: rdata_o = periph_pkg::data_t'(out_q);
      periph_pkg::GPIO_EN:  rdata_o = periph_pkg::data_t'(en_q);
      periph_pkg::GPIO_IN:  rdata_o = periph_pkg::data_t'(sync2_q);
      periph_pkg::GPIO_IE:  rdata_o = periph_pkg::data_t'(ie_q);
      default:              rdata_o = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = en_q;
  assign irq_o     = |(sync2_q & ie_q);

endmodule : periph_gpio

//--- rtl/periph_timer.sv
`timescale 1ns/10ps
// Compare timer
// Free-running counter, expired interrupt while count is at or past compare
module periph_timer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  output periph_pkg::data_t rdata_o,
  output logic              irq_o
);

  periph_pkg::data_t count_q;
  periph_pkg::data_t cmp_q;
  logic              en_q;
  periph_pkg::off_t  off;
  logic              wr;

  assign off = addr_i[7:0];
  assign wr  = valid_i && we_i;

  // Host write to the count wins over the increment
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= '0;
    end else if (wr && off == periph_pkg::TMR_COUNT) begin
      count_q <= wdata_i;
    end else if (en_q) begin
      count_q <= count_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cmp_q <= '0;
      en_q  <= 1'b0;
    end else if (wr) begin
      case (off)
        periph_pkg::TMR_CMP:  cmp_q <= wdata_i;
        periph_pkg::TMR_CTRL: en_q  <= wdata_i[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (off)
      periph_pkg::TMR_COUNT: rdata_o = count_q;
      periph_pkg::TMR_CMP:   rdata_o = cmp_q;
      periph_pkg::TMR_CTRL:  rdata_o = periph_pkg::data_t'(en_q);
      default:               rdata_o = '0;
    endcase
  end

  assign irq_o = en_q && (count_q >= cmp_q);

endmodule : periph_timer

//--- rtl/periph_plic.sv
`timescale 1ns/10ps
// Interrupt controller
// Edge-captured pending bits, enable mask and a lowest-id-first claim
module periph_plic (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              valid_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  output periph_pkg::data_t rdata_o,
  input  periph_pkg::src_t  src_i,
  output logic              irq_o
);

  periph_pkg::src_t    src_in;
  periph_pkg::src_t    src_q;
  periph_pkg::src_t    pend_q;
  periph_pkg::src_t    en_q;
  periph_pkg::src_t    active;
  periph_pkg::src_t    rise;
  periph_pkg::src_t    clr;
  periph_pkg::src_id_t claim_id;
  periph_pkg::off_t    off;
  logic                claim_rd;

  // Id 0 means no interrupt and is never a source
  assign src_in = {src_i[periph_pkg::NUM_SRC-1:1], 1'b0};
  assign rise   = src_in & ~src_q;
  assign active = pend_q & en_q;

  assign off      = addr_i[7:0];
  assign claim_rd = valid_i && !we_i && (off == periph_pkg::PLIC_CLAIM);

  always_comb begin
    claim_id = '0;
    for (int i = periph_pkg::NUM_SRC - 1; i > 0; i--) begin
      if (active[i]) claim_id = periph_pkg::src_id_t'(i);
    end
  end

  assign clr = claim_rd ? (periph_pkg::src_t'(1) << claim_id) : '0;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      src_q  <= '0;
      pend_q <= '0;
    end else begin
      src_q  <= src_in;
      // A new edge in the claim cycle stays pending
      pend_q <= (pend_q & ~clr) | rise;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q <= '0;
    end else if (valid_i && we_i && off == periph_pkg::PLIC_EN) begin
      en_q <= wdata_i[periph_pkg::NUM_SRC-1:0];
    end
  end

  always_comb begin
    case (off)
      periph_pkg::PLIC_PEND:  rdata_o = periph_pkg::data_t'(pend_q);
      periph_pkg::PLIC_EN:    rdata_o = periph_pkg::data_t'(en_q);
      periph_pkg::PLIC_CLAIM: rdata_o = periph_pkg::data_t'(claim_id);
      default:                rdata_o = '0;
    endcase
  end

  assign irq_o = |active;

  // A claim yields a source id exactly when the irq line is raised
  a_claim_matches_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    claim_rd |-> ((claim_id != '0) == irq_o));

endmodule : periph_plic

//--- rtl/periph_subsystem.sv
`timescale 1ns/10ps
// Peripheral subsystem top
// Host bridge, address decoder, GPIO, timer and interrupt controller
module periph_subsystem (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              req_i,
  input  logic              we_i,
  input  periph_pkg::addr_t addr_i,
  input  periph_pkg::data_t wdata_i,
  output logic              ack_o,
  output periph_pkg::data_t rdata_o,
  output logic              err_o,
  input  periph_pkg::gpio_t gpio_i,
  output periph_pkg::gpio_t gpio_o,
  output periph_pkg::gpio_t gpio_en_o,
  input  logic              ext_irq_i,
  output logic              irq_o
);

  logic              reg_valid;
  logic              reg_we;
  periph_pkg::addr_t reg_addr;
  periph_pkg::data_t reg_wdata;
  periph_pkg::data_t reg_rdata;
  logic              reg_err;
  logic              gpio_valid;
  logic              tmr_valid;
  logic              plic_valid;
  periph_pkg::data_t gpio_rdata;
  periph_pkg::data_t tmr_rdata;
  periph_pkg::data_t plic_rdata;
  logic              gpio_irq;
  logic              tmr_irq;

  periph_bus_bridge u_bridge (
    .clk_i, .rst_n_i, .req_i, .we_i, .addr_i, .wdata_i, .ack_o, .rdata_o, .err_o,
    .reg_valid_o(reg_valid), .reg_we_o(reg_we), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_rdata_i(reg_rdata), .reg_err_i(reg_err)
  );

  periph_addr_decode u_decode (
    .reg_valid_i(reg_valid), .reg_addr_i(reg_addr),
    .gpio_valid_o(gpio_valid), .tmr_valid_o(tmr_valid), .plic_valid_o(plic_valid),
    .gpio_rdata_i(gpio_rdata), .tmr_rdata_i(tmr_rdata), .plic_rdata_i(plic_rdata),
    .reg_rdata_o(reg_rdata), .reg_err_o(reg_err)
  );

  periph_gpio u_gpio (
    .clk_i, .rst_n_i, .valid_i(gpio_valid), .we_i(reg_we), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .rdata_o(gpio_rdata),
    .gpio_i, .gpio_o, .gpio_en_o, .irq_o(gpio_irq)
  );

  periph_timer u_timer (
    .clk_i, .rst_n_i, .valid_i(tmr_valid), .we_i(reg_we), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .rdata_o(tmr_rdata), .irq_o(tmr_irq)
  );

  // Sources: 0 unused, 1 GPIO, 2 timer, 3 external
  periph_plic u_plic (
    .clk_i, .rst_n_i, .valid_i(plic_valid), .we_i(reg_we), .addr_i(reg_addr),
    .wdata_i(reg_wdata), .rdata_o(plic_rdata),
    .src_i({ext_irq_i, tmr_irq, gpio_irq, 1'b0}), .irq_o
  );

endmodule : periph_subsystem

//--- tb/tb_periph_subsystem.sv
`timescale 1ns/10ps
// Testbench for the peripheral subsystem
// Replays the stim file through the host handshake, the pins and the external irq
module tb_periph_subsystem;

  localparam int CLK_PERIOD  = 4;
  localparam int LINE_CYCLES = 200;
  localparam int IRQ_WAIT    = 100;

  logic              clk_i;
  logic              rst_n_i;
  logic              req_i;
  logic              we_i;
  periph_pkg::addr_t addr_i;
  periph_pkg::data_t wdata_i;
  logic              ack_o;
  periph_pkg::data_t rdata_o;
  logic              err_o;
  periph_pkg::gpio_t gpio_i;
  periph_pkg::gpio_t gpio_o;
  periph_pkg::gpio_t gpio_en_o;
  logic              ext_irq_i;
  logic              irq_o;

  integer seed = 32'hdb6e;
  int     stim_lines = 0;

  periph_subsystem DUT (.*);

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  // Four-phase handshake with the response sampled at the falling edge
  task automatic host_access(input logic we, input periph_pkg::addr_t addr,
                             input periph_pkg::data_t wdata,
                             output periph_pkg::data_t rdata, output logic err);
    @(posedge clk_i);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    @(negedge clk_i);
    while (!ack_o) @(negedge clk_i);
    rdata = rdata_o;
    err   = err_o;
    @(posedge clk_i);
    req_i <= 1'b0;
    @(negedge clk_i);
    while (ack_o) @(negedge clk_i);
  endtask

  task automatic check_value(input string what, input periph_pkg::data_t got,
                             input periph_pkg::data_t exp_val,
                             input periph_pkg::data_t mask_val);
    assert ((got & mask_val) == (exp_val & mask_val)) else
      stop_run($sformatf("ERR %0t: %s got %h expected %h mask %h",
                         $time, what, got, exp_val, mask_val));
  endtask

  // Blocks 3 and up are unmapped
  task automatic expect_err_flag(input periph_pkg::addr_t addr, input logic err);
    assert (err == (addr[11:8] >= 4'd3)) else
      stop_run($sformatf("ERR %0t: err_o %0d for address %h", $time, err, addr));
  endtask

  initial begin
    int                fd;
    int                code;
    int                idle;
    int                waited;
    logic [63:0]       tok;
    logic [2047:0]     line;
    periph_pkg::addr_t addr;
    periph_pkg::data_t data;
    periph_pkg::data_t exp_val;
    periph_pkg::data_t mask_val;
    periph_pkg::data_t rdata;
    logic              err;

    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    gpio_i    = '0;
    ext_irq_i = 1'b0;

    fd = $fopen("tb/periph_stim.txt", "r");
    if (fd == 0) stop_run("Could not open the stim file tb/periph_stim.txt");
    while ($fgets(line, fd) != 0) stim_lines++;
    $fclose(fd);
    fd = $fopen("tb/periph_stim.txt", "r");

    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!ack_o && !irq_o && gpio_o == '0 && gpio_en_o == '0) else
      stop_run($sformatf("ERR %0t: outputs not low after reset", $time));

    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok[7:0] == "#") begin
        code = $fgets(line, fd);
        continue;
      end
      code = $fscanf(fd, "%h %h %h %h", addr, data, exp_val, mask_val);
      if (code != 4) stop_run("Malformed line in the stim file");
      idle = $unsigned($random(seed)) % 4;
      repeat (idle) @(posedge clk_i);
      case (tok[7:0])
        "W": begin
          host_access(1'b1, addr, data, rdata, err);
          expect_err_flag(addr, err);
        end
        "R": begin
          host_access(1'b0, addr, '0, rdata, err);
          expect_err_flag(addr, err);
          check_value($sformatf("read %h", addr), rdata, exp_val, mask_val);
        end
        "N": begin
          host_access(1'b0, addr, '0, rdata, err);
          expect_err_flag(addr, err);
          assert ((rdata & mask_val) != '0) else
            stop_run($sformatf("ERR %0t: read %h returned zero", $time, addr));
        end
        "P": begin
          @(posedge clk_i);
          gpio_i <= data[periph_pkg::GPIO_W-1:0];
        end
        "X": begin
          @(posedge clk_i);
          ext_irq_i <= data[0];
        end
        "Q": begin
          waited = 0;
          @(negedge clk_i);
          while (irq_o != data[0]) begin
            if (waited == IRQ_WAIT) stop_run("irq_o did not reach the expected level in time");
            @(negedge clk_i);
            waited++;
          end
        end
        "O": begin
          @(negedge clk_i);
          check_value("pins", {15'h0, irq_o, gpio_en_o, gpio_o}, exp_val, mask_val);
        end
        default: stop_run($sformatf("Unknown op %s in the stim file", tok));
      endcase
    end
    $fclose(fd);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  initial begin
    wait (stim_lines != 0);
    #(stim_lines * LINE_CYCLES * CLK_PERIOD);
    stop_run($sformatf("Timeout after %0d cycles, the run did not finish",
                       stim_lines * LINE_CYCLES));
  end

endmodule : tb_periph_subsystem

//--- tb/periph_stim.txt
# op addr data expect mask in hex; ops W write, R read, N read non-zero, P pins, X ext irq, Q wait irq level, O pin outputs {irq, en, out}
R 000 0 0 ffffffff
R 004 0 0 ffffffff
R 008 0 0 ffffffff
R 00c 0 0 ffffffff
R 100 0 0 ffffffff
R 104 0 0 ffffffff
R 108 0 0 ffffffff
R 200 0 0 ffffffff
R 204 0 0 ffffffff
R 208 0 0 ffffffff
W 000 a5 0 0
W 004 0f 0 0
O 000 0 00fa5 1ffff
R 000 0 a5 ffffffff
R 004 0 0f ffffffff
P 000 3c 0 0
R 008 0 3c ffffffff
W 300 deadbeef 0 0
R 300 0 0 ffffffff
R f04 0 0 ffffffff
R 000 0 a5 ffffffff
W 104 14 0 0
W 108 1 0 0
N 100 0 0 ffffffff
W 204 4 0 0
Q 000 1 0 0
R 208 0 2 ffffffff
W 108 0 0 0
R 208 0 0 ffffffff
Q 000 0 0 0
W 00c 1 0 0
P 000 3d 0 0
X 000 1 0 0
W 204 a 0 0
Q 000 1 0 0
R 208 0 1 ffffffff
R 208 0 3 ffffffff
R 208 0 0 ffffffff
Q 000 0 0 0
X 000 0 0 0
W 204 0 0 0
X 000 1 0 0
R 200 0 8 f
O 000 0 0 10000
R 208 0 0 ffffffff

//--- list.f
rtl/periph_pkg.sv
rtl/periph_bus_bridge.sv
rtl/periph_addr_decode.sv
rtl/periph_gpio.sv
rtl/periph_timer.sv
rtl/periph_plic.sv
rtl/periph_subsystem.sv
tb/tb_periph_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f list.f --top-module tb_periph_subsystem -o sim_tb
./obj_dir/sim_tb 2>&1 | tee sim.log || true
if grep -q "CHECKS FAILED" sim.log || ! grep -q "ALL CHECKS PASSED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
